/* src/eng_data_pkg.sv */
package eng_data_pkg;

	// One input word, data or weight
	typedef logic signed [15:0] data_t;

	// Lane result and running accumulator, wraps modulo 2^32
	typedef logic signed [31:0] acc_t;

	// Elements per window per lane
	typedef logic [7:0] ksize_t;

	// Windows in one operation
	typedef logic [15:0] count_t;

endpackage

/* src/eng_ctrl_pkg.sv */
package eng_ctrl_pkg;

	typedef enum logic [2:0] {
		OP_MAC = 3'd1,
		OP_MAX = 3'd2,
		OP_SUM = 3'd3
	} op_e;

	typedef enum logic [2:0] {
		S_IDLE,
		S_LOAD_W,
		S_WAIT_W,
		S_RUN,
		S_WAIT_DRAIN
	} ctrl_state_e;

endpackage

/* src/engine_ctrl.sv */
`timescale 1ns/1ps

module engine_ctrl import eng_ctrl_pkg::*; import eng_data_pkg::*; #(
	parameter int N_LANES = 4
) (
	input  logic   clk,
	input  logic   i_rst,
	input  logic   i_start,
	input  op_e    i_op,
	input  ksize_t i_kernel_size,
	input  count_t i_n_windows,
	input  logic   i_wgt_full,
	input  logic   i_window_out,
	output logic   o_busy,
	output logic   o_done,
	output logic   o_wgt_rd_en,
	output logic   o_data_rd_en,
	output op_e    o_op,
	output ksize_t o_kernel_size
);

	// Wide enough for N_LANES * 255 requests
	localparam int CW = $clog2(N_LANES * 256);

	ctrl_state_e state;
	count_t n_win_q;
	count_t win_cnt;
	logic [CW-1:0] req_cnt;
	logic [CW-1:0] wgt_total;
	logic [CW-1:0] win_total;

	assign wgt_total = CW'(N_LANES) * CW'(o_kernel_size);
	// MAC broadcasts each word, pooling interleaves the channels
	assign win_total = (o_op == OP_MAC) ? CW'(o_kernel_size) : wgt_total;

	assign o_busy = (state != S_IDLE);
	assign o_wgt_rd_en = (state == S_LOAD_W);
	assign o_data_rd_en = (state == S_RUN);

	always_ff @(posedge clk) begin
		if (i_rst) begin
			state <= S_IDLE;
			req_cnt <= '0;
			win_cnt <= '0;
			n_win_q <= '0;
			o_op <= OP_MAC;
			o_kernel_size <= '0;
			o_done <= 1'b0;
		end else begin
			o_done <= 1'b0;
			case (state)
				S_IDLE: begin
					if (i_start) begin
						o_op <= i_op;
						o_kernel_size <= i_kernel_size;
						n_win_q <= i_n_windows;
						req_cnt <= '0;
						win_cnt <= '0;
						state <= (i_op == OP_MAC) ? S_LOAD_W : S_RUN;
					end
				end
				S_LOAD_W: begin
					if (req_cnt == wgt_total - 1'b1) begin
						req_cnt <= '0;
						state <= S_WAIT_W;
					end else begin
						req_cnt <= req_cnt + 1'b1;
					end
				end
				// Weights still in flight
				S_WAIT_W: begin
					if (i_wgt_full)
						state <= S_RUN;
				end
				S_RUN: begin
					if (req_cnt == win_total - 1'b1) begin
						req_cnt <= '0;
						state <= S_WAIT_DRAIN;
					end else begin
						req_cnt <= req_cnt + 1'b1;
					end
				end
				S_WAIT_DRAIN: begin
					if (i_window_out) begin
						if (win_cnt == n_win_q - 1'b1) begin
							o_done <= 1'b1;
							state <= S_IDLE;
						end else begin
							win_cnt <= win_cnt + 1'b1;
							state <= S_RUN;
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	a_idle_no_req: assert property (@(posedge clk) disable iff (i_rst)
		(state == S_IDLE && !i_start) |=> !(o_wgt_rd_en || o_data_rd_en))
		else $error("read request without a start");

endmodule

/* src/lane_feeder.sv */
`timescale 1ns/1ps

module lane_feeder import eng_ctrl_pkg::*; import eng_data_pkg::*; #(
	parameter int N_LANES = 4,
	parameter int MAX_KSIZE = 16
) (
	input  logic                         clk,
	input  logic                         i_rst,
	input  logic                         i_start,
	input  op_e                          i_op,
	input  ksize_t                       i_kernel_size,
	input  logic                         i_wgt_we,
	input  data_t                        i_wgt_data,
	input  logic                         i_data_we,
	input  data_t                        i_data,
	output logic [N_LANES-1:0]           o_wgt_we,
	output logic [$clog2(MAX_KSIZE)-1:0] o_wgt_addr,
	output logic [N_LANES-1:0]           o_elem_we,
	output ksize_t                       o_elem_idx,
	output logic                         o_elem_last,
	output data_t                        o_elem_data,
	output logic                         o_wgt_full
);

	localparam int AW = $clog2(MAX_KSIZE);
	localparam int LW = (N_LANES > 1) ? $clog2(N_LANES) : 1;

	logic [LW-1:0] wgt_lane;
	logic [LW-1:0] data_lane;
	ksize_t wgt_elem;
	ksize_t data_elem;
	logic wgt_elem_end;
	logic wgt_lane_end;
	logic data_elem_end;
	logic data_lane_end;
	logic pool;

	assign pool = (i_op != OP_MAC);
	assign wgt_elem_end = (wgt_elem == i_kernel_size - 1'b1);
	assign wgt_lane_end = (wgt_lane == LW'(N_LANES - 1));
	assign data_elem_end = (data_elem == i_kernel_size - 1'b1);
	assign data_lane_end = (data_lane == LW'(N_LANES - 1));

	// Weights arrive lane-major, pooling data channel-interleaved
	always_ff @(posedge clk) begin
		if (i_rst || i_start) begin
			wgt_lane <= '0;
			wgt_elem <= '0;
			data_lane <= '0;
			data_elem <= '0;
		end else begin
			if (i_wgt_we) begin
				if (wgt_elem_end) begin
					wgt_elem <= '0;
					wgt_lane <= wgt_lane_end ? '0 : wgt_lane + 1'b1;
				end else begin
					wgt_elem <= wgt_elem + 1'b1;
				end
			end
			if (i_data_we) begin
				if (pool && !data_lane_end) begin
					data_lane <= data_lane + 1'b1;
				end else begin
					data_lane <= '0;
					data_elem <= data_elem_end ? '0 : data_elem + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_wgt_we <= '0;
			o_elem_we <= '0;
			o_elem_last <= 1'b0;
			o_wgt_full <= 1'b0;
		end else begin
			o_wgt_we <= i_wgt_we ? (N_LANES'(1) << wgt_lane) : '0;
			if (!i_data_we)
				o_elem_we <= '0;
			else
				o_elem_we <= pool ? (N_LANES'(1) << data_lane) : '1;
			o_elem_last <= i_data_we && data_elem_end;
			o_wgt_full <= i_wgt_we && wgt_elem_end && wgt_lane_end;
		end
	end

	// Weights and data never overlap, so one word register serves both
	always_ff @(posedge clk) begin
		if (i_wgt_we) begin
			o_elem_data <= i_wgt_data;
			o_wgt_addr <= wgt_elem[AW-1:0];
		end else if (i_data_we) begin
			o_elem_data <= i_data;
			o_elem_idx <= data_elem;
		end
	end

	a_pool_onehot: assert property (@(posedge clk) disable iff (i_rst)
		(pool && i_data_we) |=> $onehot(o_elem_we))
		else $error("pooling word not sent to exactly one lane");

endmodule

/* src/pe_lane.sv */
`timescale 1ns/1ps

module pe_lane import eng_ctrl_pkg::*; import eng_data_pkg::*; #(
	parameter int MAX_KSIZE = 16
) (
	input  logic                         clk,
	input  logic                         i_rst,
	input  op_e                          i_op,
	input  logic                         i_wgt_we,
	input  logic [$clog2(MAX_KSIZE)-1:0] i_wgt_addr,
	input  data_t                        i_wgt_data,
	input  logic                         i_elem_we,
	input  ksize_t                       i_elem_idx,
	input  logic                         i_elem_last,
	input  data_t                        i_elem_data,
	output logic                         o_done,
	output acc_t                         o_result
);

	localparam int AW = $clog2(MAX_KSIZE);

	data_t wgt_mem [MAX_KSIZE];
	data_t wgt_rd;
	acc_t acc;
	acc_t elem;
	acc_t term;
	acc_t acc_next;

	always_ff @(posedge clk) begin
		if (i_wgt_we)
			wgt_mem[i_wgt_addr] <= i_wgt_data;
	end

	assign wgt_rd = wgt_mem[i_elem_idx[AW-1:0]];
	assign elem = acc_t'(i_elem_data);
	assign term = (i_op == OP_MAC) ? elem * acc_t'(wgt_rd) : elem;

	// First element of a window restarts the accumulator
	always_comb begin
		if (i_elem_idx == '0) begin
			acc_next = term;
		end else begin
			case (i_op)
				OP_MAC, OP_SUM: acc_next = acc + term;
				OP_MAX: acc_next = (term > acc) ? term : acc;
				default: acc_next = acc;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (i_elem_we)
			acc <= acc_next;
		if (i_elem_we && i_elem_last)
			o_result <= acc_next;
	end

	always_ff @(posedge clk) begin
		if (i_rst)
			o_done <= 1'b0;
		else
			o_done <= i_elem_we && i_elem_last;
	end

	a_no_wgt_during_elem: assert property (@(posedge clk) disable iff (i_rst)
		!(i_wgt_we && i_elem_we))
		else $error("weight write during element strobe");

endmodule

/* src/result_drain.sv */
`timescale 1ns/1ps

module result_drain import eng_data_pkg::*; #(
	parameter int N_LANES = 4
) (
	input  logic               clk,
	input  logic               i_rst,
	input  logic [N_LANES-1:0] i_lane_done,
	input  acc_t [N_LANES-1:0] i_lane_result,
	output logic               o_res_valid,
	output acc_t               o_res_data,
	output logic               o_busy,
	output logic               o_window_out
);

	localparam int LW = (N_LANES > 1) ? $clog2(N_LANES) : 1;

	acc_t cap [N_LANES];
	logic [N_LANES-1:0] got;
	logic [LW-1:0] out_idx;
	logic emitting;
	logic last_out;

	always_ff @(posedge clk) begin
		for (int l = 0; l < N_LANES; l++) begin
			if (i_lane_done[l])
				cap[l] <= i_lane_result[l];
		end
	end

	assign last_out = (out_idx == LW'(N_LANES - 1));

	// Last lane done starts the emission, lane 0 first
	always_ff @(posedge clk) begin
		if (i_rst) begin
			emitting <= 1'b0;
			out_idx <= '0;
			got <= '0;
		end else if (i_lane_done[N_LANES-1]) begin
			emitting <= 1'b1;
			out_idx <= '0;
			got <= '0;
		end else begin
			got <= got | i_lane_done;
			if (emitting) begin
				out_idx <= last_out ? '0 : out_idx + 1'b1;
				if (last_out)
					emitting <= 1'b0;
			end
		end
	end

	assign o_res_valid = emitting;
	assign o_res_data = cap[out_idx];
	assign o_window_out = emitting && last_out;
	assign o_busy = emitting || (|got);

	a_no_done_while_emit: assert property (@(posedge clk) disable iff (i_rst)
		emitting |-> !(|i_lane_done))
		else $error("lane result arrived while draining");

endmodule

/* src/engine.sv */
`timescale 1ns/1ps

module engine import eng_ctrl_pkg::*; import eng_data_pkg::*; #(
	parameter int N_LANES = 4,
	parameter int MAX_KSIZE = 16
) (
	input  logic   clk,
	input  logic   i_rst,
	input  logic   i_start,
	input  op_e    i_op,
	input  ksize_t i_kernel_size,
	input  count_t i_n_windows,
	output logic   o_busy,
	output logic   o_done,
	output logic   o_wgt_rd_en,
	input  logic   i_wgt_we,
	input  data_t  i_wgt_data,
	output logic   o_data_rd_en,
	input  logic   i_data_we,
	input  data_t  i_data,
	output logic   o_res_valid,
	output acc_t   o_res_data
);

	localparam int AW = $clog2(MAX_KSIZE);

	op_e op;
	ksize_t kernel_size;
	logic wgt_full;
	logic window_out;
	logic drain_busy;
	logic [N_LANES-1:0] wgt_we;
	logic [N_LANES-1:0] elem_we;
	logic [AW-1:0] wgt_addr;
	ksize_t elem_idx;
	logic elem_last;
	data_t elem_data;
	logic [N_LANES-1:0] lane_done;
	acc_t [N_LANES-1:0] lane_result;

	engine_ctrl #(.N_LANES(N_LANES)) u_ctrl (
		.clk           (clk),
		.i_rst         (i_rst),
		.i_start       (i_start),
		.i_op          (i_op),
		.i_kernel_size (i_kernel_size),
		.i_n_windows   (i_n_windows),
		.i_wgt_full    (wgt_full),
		.i_window_out  (window_out),
		.o_busy        (o_busy),
		.o_done        (o_done),
		.o_wgt_rd_en   (o_wgt_rd_en),
		.o_data_rd_en  (o_data_rd_en),
		.o_op          (op),
		.o_kernel_size (kernel_size)
	);

	// Feeder counters restart only on an accepted start
	lane_feeder #(.N_LANES(N_LANES), .MAX_KSIZE(MAX_KSIZE)) u_feeder (
		.clk           (clk),
		.i_rst         (i_rst),
		.i_start       (i_start && !o_busy),
		.i_op          (op),
		.i_kernel_size (kernel_size),
		.i_wgt_we      (i_wgt_we),
		.i_wgt_data    (i_wgt_data),
		.i_data_we     (i_data_we),
		.i_data        (i_data),
		.o_wgt_we      (wgt_we),
		.o_wgt_addr    (wgt_addr),
		.o_elem_we     (elem_we),
		.o_elem_idx    (elem_idx),
		.o_elem_last   (elem_last),
		.o_elem_data   (elem_data),
		.o_wgt_full    (wgt_full)
	);

	for (genvar g = 0; g < N_LANES; g++) begin : g_lane
		pe_lane #(.MAX_KSIZE(MAX_KSIZE)) u_lane (
			.clk         (clk),
			.i_rst       (i_rst),
			.i_op        (op),
			.i_wgt_we    (wgt_we[g]),
			.i_wgt_addr  (wgt_addr),
			.i_wgt_data  (elem_data),
			.i_elem_we   (elem_we[g]),
			.i_elem_idx  (elem_idx),
			.i_elem_last (elem_last),
			.i_elem_data (elem_data),
			.o_done      (lane_done[g]),
			.o_result    (lane_result[g])
		);
	end

	result_drain #(.N_LANES(N_LANES)) u_drain (
		.clk           (clk),
		.i_rst         (i_rst),
		.i_lane_done   (lane_done),
		.i_lane_result (lane_result),
		.o_res_valid   (o_res_valid),
		.o_res_data    (o_res_data),
		.o_busy        (drain_busy),
		.o_window_out  (window_out)
	);

	a_drain_in_op: assert property (@(posedge clk) disable iff (i_rst)
		drain_busy |-> o_busy)
		else $error("result side active outside an operation");

endmodule

/* verification/engine_tb.sv */
`timescale 1ns/1ps

module engine_tb import eng_ctrl_pkg::*; import eng_data_pkg::*; ();

	localparam int N_LANES = 4;
	localparam int MAX_KSIZE = 16;
	localparam int N_ROWS = 7;
	localparam int TIMEOUT = 5000;

	typedef struct packed {
		op_e    op;
		ksize_t ks;
		count_t nwin;
		count_t n_res;
	} row_t;

	logic clk;
	logic i_rst;
	logic i_start;
	op_e i_op;
	ksize_t i_kernel_size;
	count_t i_n_windows;
	logic o_busy;
	logic o_done;
	logic o_wgt_rd_en;
	logic i_wgt_we;
	data_t i_wgt_data;
	logic o_data_rd_en;
	logic i_data_we;
	data_t i_data;
	logic o_res_valid;
	acc_t o_res_data;

	row_t rows [N_ROWS];
	data_t wgt_words [$];
	data_t dat_words [$];
	acc_t exp_res [$];
	acc_t got_res [$];
	int wgt_due [$];
	int dat_due [$];
	int wgt_last_due;
	int dat_last_due;
	int wgt_idx;
	int dat_idx;
	int wgt_reqs;
	int dat_reqs;
	int cyc;
	int last_res_cyc;
	int done_cyc;
	int done_cnt;
	int err_value;
	int err_other;
	bit timed_out;

	engine #(.N_LANES(N_LANES), .MAX_KSIZE(MAX_KSIZE)) i_engine (
		.clk           (clk),
		.i_rst         (i_rst),
		.i_start       (i_start),
		.i_op          (i_op),
		.i_kernel_size (i_kernel_size),
		.i_n_windows   (i_n_windows),
		.o_busy        (o_busy),
		.o_done        (o_done),
		.o_wgt_rd_en   (o_wgt_rd_en),
		.i_wgt_we      (i_wgt_we),
		.i_wgt_data    (i_wgt_data),
		.o_data_rd_en  (o_data_rd_en),
		.i_data_we     (i_data_we),
		.i_data        (i_data),
		.o_res_valid   (o_res_valid),
		.o_res_data    (o_res_data)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk)
		cyc <= cyc + 1;

	// In-order answer slot, 1 to 3 cycles after the request
	function automatic int next_due(int last);
		int d;
		d = cyc + int'($urandom_range(3, 1));
		return (d > last) ? d : last + 1;
	endfunction

	// DMA model for both read channels
	always @(posedge clk) begin
		if (i_rst) begin
			wgt_due.delete();
			dat_due.delete();
			wgt_last_due = 0;
			dat_last_due = 0;
			i_wgt_we <= 1'b0;
			i_data_we <= 1'b0;
		end else begin
			if (o_wgt_rd_en) begin
				wgt_last_due = next_due(wgt_last_due);
				wgt_due.push_back(wgt_last_due);
				wgt_reqs++;
			end
			if (o_data_rd_en) begin
				dat_last_due = next_due(dat_last_due);
				dat_due.push_back(dat_last_due);
				dat_reqs++;
			end
			i_wgt_we <= 1'b0;
			i_data_we <= 1'b0;
			if (wgt_due.size() > 0 && wgt_due[0] == cyc) begin
				void'(wgt_due.pop_front());
				i_wgt_we <= 1'b1;
				i_wgt_data <= wgt_words[wgt_idx];
				wgt_idx++;
			end
			if (dat_due.size() > 0 && dat_due[0] == cyc) begin
				void'(dat_due.pop_front());
				i_data_we <= 1'b1;
				i_data <= dat_words[dat_idx];
				dat_idx++;
			end
		end
	end

	// Result port monitor
	always @(posedge clk) begin
		if (!i_rst) begin
			if (o_res_valid) begin
				got_res.push_back(o_res_data);
				last_res_cyc = cyc;
			end
			if (o_done) begin
				done_cnt++;
				done_cyc = cyc;
				if (o_busy) begin
					err_other++;
					$display("o_busy still high on the o_done cycle");
				end
			end
		end
	end

	task automatic result_compare(input string name, input acc_t got, input acc_t exp);
		if (got !== exp) begin
			err_value++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic count_compare(input string name, input count_t got, input count_t exp);
		if (got !== exp) begin
			err_value++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic request_compare(input string name, input count_t got, input count_t exp);
		if (got !== exp) begin
			err_value++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	function automatic row_t make_row(op_e op, ksize_t ks, count_t nwin, count_t n_res);
		row_t r;
		r.op = op;
		r.ks = ks;
		r.nwin = nwin;
		r.n_res = n_res;
		return r;
	endfunction

	// SUM rows use words near both ends of the range
	function automatic data_t make_word(op_e op);
		logic [31:0] r;
		r = $urandom;
		if (op == OP_SUM)
			return r[16] ? data_t'({8'h7f, r[7:0]}) : data_t'({8'h80, r[7:0]});
		return data_t'(r[15:0]);
	endfunction

	// Expected results from the recorded words, lane 0 first per window
	task automatic build_expected(input op_e op, input int ks, input int nwin);
		acc_t acc;
		acc_t v;
		exp_res.delete();
		for (int w = 0; w < nwin; w++) begin
			for (int l = 0; l < N_LANES; l++) begin
				acc = '0;
				for (int e = 0; e < ks; e++) begin
					if (op == OP_MAC)
						v = acc_t'(dat_words[w * ks + e]) * acc_t'(wgt_words[l * ks + e]);
					else
						v = acc_t'(dat_words[(w * ks + e) * N_LANES + l]);
					if (e == 0)
						acc = v;
					else if (op == OP_MAX)
						acc = (v > acc) ? v : acc;
					else
						acc = acc + v;
				end
				exp_res.push_back(acc);
			end
		end
	endtask

	task automatic watch_idle(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			if (o_busy || o_done || o_wgt_rd_en || o_data_rd_en || o_res_valid) begin
				err_other++;
				$display("control or request output high while idle after reset");
			end
		end
	endtask

	task automatic run_row(input int idx, input row_t r);
		int n_wgt;
		int n_dat;
		bit seen;
		n_wgt = (r.op == OP_MAC) ? N_LANES * r.ks : 0;
		n_dat = (r.op == OP_MAC) ? r.nwin * r.ks : r.nwin * N_LANES * r.ks;
		wgt_words.delete();
		dat_words.delete();
		for (int i = 0; i < n_wgt; i++)
			wgt_words.push_back(make_word(r.op));
		for (int i = 0; i < n_dat; i++)
			dat_words.push_back(make_word(r.op));
		build_expected(r.op, r.ks, r.nwin);
		wgt_idx = 0;
		dat_idx = 0;
		wgt_reqs = 0;
		dat_reqs = 0;
		done_cnt = 0;
		got_res.delete();
		@(posedge clk);
		i_start <= 1'b1;
		i_op <= r.op;
		i_kernel_size <= r.ks;
		i_n_windows <= r.nwin;
		@(posedge clk);
		i_start <= 1'b0;
		@(posedge clk);
		if (!o_busy) begin
			err_other++;
			$display("row %0d: o_busy did not rise the cycle after start", idx);
		end
		seen = 1'b0;
		for (int n = 0; n < TIMEOUT && !seen; n++) begin
			@(posedge clk);
			seen = o_done;
		end
		if (!seen) begin
			err_other++;
			timed_out = 1'b1;
			$display("row %0d: timed out waiting for o_done", idx);
			return;
		end
		@(posedge clk);
		count_compare("o_res_valid strobes", count_t'(got_res.size()), r.n_res);
		request_compare("o_wgt_rd_en cycles", count_t'(wgt_reqs), count_t'(n_wgt));
		request_compare("o_data_rd_en cycles", count_t'(dat_reqs), count_t'(n_dat));
		for (int i = 0; i < exp_res.size() && i < got_res.size(); i++)
			result_compare($sformatf("o_res_data[%0d] row %0d", i, idx), got_res[i], exp_res[i]);
		if (done_cnt != 1) begin
			err_other++;
			$display("row %0d: o_done pulsed %0d times", idx, done_cnt);
		end
		if (done_cyc != last_res_cyc + 1) begin
			err_other++;
			$display("row %0d: o_done not one cycle after the final result", idx);
		end
	endtask

	initial begin
		void'($urandom(32'h22dad290));
		cyc = 0;
		err_value = 0;
		err_other = 0;
		timed_out = 1'b0;
		done_cnt = 0;
		i_rst = 1'b1;
		i_start = 1'b0;
		i_op = OP_MAC;
		i_kernel_size = '0;
		i_n_windows = '0;
		i_wgt_we = 1'b0;
		i_wgt_data = '0;
		i_data_we = 1'b0;
		i_data = '0;
		rows[0] = make_row(OP_MAC, 8'd9, 16'd2, 16'd8);
		rows[1] = make_row(OP_MAC, 8'd1, 16'd3, 16'd12);
		rows[2] = make_row(OP_MAX, 8'd5, 16'd2, 16'd8);
		rows[3] = make_row(OP_SUM, 8'd16, 16'd2, 16'd8);
		rows[4] = make_row(OP_MAX, 8'd3, 16'd1, 16'd4);
		rows[5] = make_row(OP_MAC, 8'd4, 16'd2, 16'd8);
		rows[6] = make_row(OP_SUM, 8'd2, 16'd3, 16'd12);
		repeat (5) @(posedge clk);
		i_rst <= 1'b0;
		watch_idle(10);
		for (int r = 0; r < N_ROWS; r++) begin
			if (!timed_out)
				run_row(r, rows[r]);
		end
		$display("errors: %0d value, %0d other", err_value, err_other);
		if (err_value == 0 && err_other == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

/* vlog.f */
src/eng_data_pkg.sv
src/eng_ctrl_pkg.sv
src/engine_ctrl.sv
src/lane_feeder.sv
src/pe_lane.sv
src/result_drain.sv
src/engine.sv
verification/engine_tb.sv
